// File: rtl/headingTrigTable.sv
/*
  Constant sin/cos table for the 45 headings, 8 degrees apart, CCW from +x.
  Values are round(127 * f) in sign-magnitude. Only heading 0 sits on an axis.
  Pure combinational. Headings above 44 read as heading 0.
*/
`timescale 1ns/1ps
`default_nettype none

module headingTrigTable
(
    input  tankPkg::headingT  heading,
    output tankPkg::trigPairT trig
);
    import tankPkg::*;

    // Positive entry
    function automatic trigT pv(input logic [6:0] mag);
        return {1'b0, mag};
    endfunction

    // Negative entry
    function automatic trigT nv(input logic [6:0] mag);
        return {1'b1, mag};
    endfunction

    always_comb
    begin
        case (heading)
            // Quadrant I, sin then cos
            6'd0:    trig = {pv(7'd0),   pv(7'd127)};
            6'd1:    trig = {pv(7'd18),  pv(7'd126)};
            6'd2:    trig = {pv(7'd35),  pv(7'd122)};
            6'd3:    trig = {pv(7'd52),  pv(7'd116)};
            6'd4:    trig = {pv(7'd67),  pv(7'd108)};
            6'd5:    trig = {pv(7'd82),  pv(7'd97)};
            6'd6:    trig = {pv(7'd94),  pv(7'd85)};
            6'd7:    trig = {pv(7'd105), pv(7'd71)};
            6'd8:    trig = {pv(7'd114), pv(7'd56)};
            6'd9:    trig = {pv(7'd121), pv(7'd39)};
            6'd10:   trig = {pv(7'd125), pv(7'd22)};
            6'd11:   trig = {pv(7'd127), pv(7'd4)};    // 88 deg
            // Quadrant II
            6'd12:   trig = {pv(7'd126), nv(7'd13)};
            6'd13:   trig = {pv(7'd123), nv(7'd31)};
            6'd14:   trig = {pv(7'd118), nv(7'd48)};
            6'd15:   trig = {pv(7'd110), nv(7'd64)};
            6'd16:   trig = {pv(7'd100), nv(7'd78)};
            6'd17:   trig = {pv(7'd88),  nv(7'd91)};
            6'd18:   trig = {pv(7'd75),  nv(7'd103)};
            6'd19:   trig = {pv(7'd60),  nv(7'd112)};
            6'd20:   trig = {pv(7'd43),  nv(7'd119)};
            6'd21:   trig = {pv(7'd26),  nv(7'd124)};
            6'd22:   trig = {pv(7'd9),   nv(7'd127)};  // 176 deg
            // Quadrant III
            6'd23:   trig = {nv(7'd9),   nv(7'd127)};
            6'd24:   trig = {nv(7'd26),  nv(7'd124)};
            6'd25:   trig = {nv(7'd43),  nv(7'd119)};
            6'd26:   trig = {nv(7'd60),  nv(7'd112)};
            6'd27:   trig = {nv(7'd75),  nv(7'd103)};
            6'd28:   trig = {nv(7'd88),  nv(7'd91)};
            6'd29:   trig = {nv(7'd100), nv(7'd78)};
            6'd30:   trig = {nv(7'd110), nv(7'd64)};
            6'd31:   trig = {nv(7'd118), nv(7'd48)};
            6'd32:   trig = {nv(7'd123), nv(7'd31)};
            6'd33:   trig = {nv(7'd126), nv(7'd13)};
            // Quadrant IV
            6'd34:   trig = {nv(7'd127), pv(7'd4)};
            6'd35:   trig = {nv(7'd125), pv(7'd22)};
            6'd36:   trig = {nv(7'd121), pv(7'd39)};
            6'd37:   trig = {nv(7'd114), pv(7'd56)};
            6'd38:   trig = {nv(7'd105), pv(7'd71)};
            6'd39:   trig = {nv(7'd94),  pv(7'd85)};
            6'd40:   trig = {nv(7'd82),  pv(7'd97)};
            6'd41:   trig = {nv(7'd67),  pv(7'd108)};
            6'd42:   trig = {nv(7'd52),  pv(7'd116)};
            6'd43:   trig = {nv(7'd35),  pv(7'd122)};
            6'd44:   trig = {nv(7'd18),  pv(7'd126)};  // 352 deg
            default: trig = {pv(7'd0),   pv(7'd127)};  // Unused codes
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/keyDecoder.sv
/*
  Four keycode slots are scanned every frame. The highest-priority key found
  in any slot wins. Order is forward, reverse, rotLeft, rotRight, fire.
  The command is registered, so it lags the keyboard report by one frame.
*/
`timescale 1ns/1ps
`default_nettype none

module keyDecoder
(
    input  logic                   Reset,      // Frame clock
    input  logic                   frame_clk,  // Async reset, active high
    input  tankPkg::keyCodeT [3:0] keycode,
    output tankPkg::tankCmdT       cmd
);
    import tankPkg::*;

    localparam keyCodeT keyFwd      = 8'h52;  // Up arrow
    localparam keyCodeT keyRev      = 8'h51;  // Down arrow
    localparam keyCodeT keyRotLeft  = 8'h50;  // Left arrow
    localparam keyCodeT keyRotRight = 8'h4F;  // Right arrow
    localparam keyCodeT keyFire     = 8'h2C;  // Space bar

    tankCmdT seen;  // Any slot holds the key
    tankCmdT pick;  // Priority winner

    always_comb
    begin
        seen = '0;
        for (int i = 0; i < $size(keycode); i++)
        begin
            seen.forward  |= (keycode[i] == keyFwd);
            seen.reverse  |= (keycode[i] == keyRev);
            seen.rotLeft  |= (keycode[i] == keyRotLeft);
            seen.rotRight |= (keycode[i] == keyRotRight);
            seen.fire     |= (keycode[i] == keyFire);
        end
    end

    always_comb
    begin
        pick = '0;
        if (seen.forward)
            pick.forward = 1'b1;
        else if (seen.reverse)
            pick.reverse = 1'b1;
        else if (seen.rotLeft)
            pick.rotLeft = 1'b1;
        else if (seen.rotRight)
            pick.rotRight = 1'b1;
        else if (seen.fire)
            pick.fire = 1'b1;  // Fire only when no other key
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
            cmd <= '0;
        else
            cmd <= pick;  // One frame of latency
    end

endmodule

`default_nettype wire

// File: rtl/tankControl.sv
/*
  Central decisions of the tank. Priority is hit, then walls, then drive.
  Heading wraps over 0..44. Fire pulses for one frame and then waits out
  reloadFrames frames, so a held key fires once every reloadFrames frames.
  A hit clears heading, fire pulse and reload.
*/
`timescale 1ns/1ps
`default_nettype none

module tankControl
#(
    parameter int reloadFrames = 6
)
(
    input  logic               Reset,      // Frame clock
    input  logic               frame_clk,  // Async reset, active high
    input  logic               hit,
    input  tankPkg::tankCmdT   cmd,
    input  tankPkg::wallFlagsT walls,
    output tankPkg::headingT   heading,
    output tankPkg::motionSelT motionSel,
    output logic               shootBullet
);
    import tankPkg::*;

    localparam int cntW = (reloadFrames > 2) ? $clog2(reloadFrames) : 1;

    localparam headingT lastHeading = headingT'(headingCount - 1);
    localparam logic [cntW-1:0] reloadLoad = cntW'(reloadFrames - 1);

    fireStateT       fireState;
    logic [cntW-1:0] reloadCnt;  // Frames left in reload

    // --------------------
    // Motion select
    // --------------------
    always_comb
    begin
        if (hit)
            motionSel = respawn;
        else if (|walls)
            motionSel = bounce;  // Walls override drive keys
        else if (cmd.forward)
            motionSel = driveFwd;
        else if (cmd.reverse)
            motionSel = driveRev;
        else
            motionSel = holdStill;
    end

    // --------------------
    // Heading counter
    // --------------------
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
            heading <= '0;
        else if (hit)
            heading <= '0;  // Respawn faces +x
        else if (cmd.rotLeft)
            heading <= (heading == lastHeading) ? '0 : heading + 1'b1;
        else if (cmd.rotRight)
            heading <= (heading == '0) ? lastHeading : heading - 1'b1;
    end

    // --------------------
    // Fire and reload FSM
    // --------------------
    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            fireState   <= fireReady;
            reloadCnt   <= '0;
            shootBullet <= 1'b0;
        end
        else if (hit)
        begin
            fireState   <= fireReady;
            reloadCnt   <= '0;
            shootBullet <= 1'b0;
        end
        else
        begin
            case (fireState)
                fireReady:
                begin
                    shootBullet <= cmd.fire;  // One-frame pulse
                    if (cmd.fire)
                    begin
                        fireState <= fireReload;
                        reloadCnt <= reloadLoad;
                    end
                end
                fireReload:
                begin
                    shootBullet <= 1'b0;
                    if (reloadCnt != '0)
                        reloadCnt <= reloadCnt - 1'b1;
                    if (reloadCnt <= cntW'(1))
                        fireState <= fireReady;  // Ready as count hits zero
                end
                default:
                begin
                    fireState   <= fireReady;
                    shootBullet <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/tankMotion.sv
/*
  Step and position registers. Position always adds the step held before
  the edge, so a new step shows in the position one frame later.
  Forward step magnitude is floor(driveSpeed * |trig| / 128).
  Respawn zeroes the step and puts the tank back at the centre.
*/
`timescale 1ns/1ps
`default_nettype none

module tankMotion
#(
    parameter logic [6:0]     driveSpeed = 7'd8,
    parameter tankPkg::coordT centerX    = 10'd300,
    parameter tankPkg::coordT centerY    = 10'd250
)
(
    input  logic               Reset,      // Frame clock
    input  logic               frame_clk,  // Async reset, active high
    input  tankPkg::motionSelT motionSel,
    input  tankPkg::trigPairT  trig,
    output tankPkg::tankPosT   pos,
    output tankPkg::stepT      stepX,
    output tankPkg::stepT      stepY
);
    import tankPkg::*;

    logic [13:0] prodX;  // Speed times |cos|
    logic [13:0] prodY;  // Speed times |sin|
    logic [6:0]  magX;
    logic [6:0]  magY;
    stepT        fwdX;
    stepT        fwdY;
    stepT        nextX;
    stepT        nextY;

    // --------------------
    // Forward step per axis
    // --------------------
    always_comb
    begin
        prodX = driveSpeed * trig.cos[6:0];
        prodY = driveSpeed * trig.sin[6:0];
        magX  = prodX[13:7];  // Divide by 128, floor
        magY  = prodY[13:7];

        fwdX = trig.cos[7] ? -stepT'(magX) : stepT'(magX);
        fwdY = trig.sin[7] ? stepT'(magY) : -stepT'(magY);  // Screen y points down
    end

    // --------------------
    // Step select
    // --------------------
    always_comb
    begin
        case (motionSel)
            driveFwd:
            begin
                nextX = fwdX;
                nextY = fwdY;
            end
            driveRev:
            begin
                nextX = -fwdX;
                nextY = -fwdY;
            end
            bounce:
            begin
                nextX = -stepX;  // Reflect current motion
                nextY = -stepY;
            end
            default:
            begin
                nextX = '0;  // holdStill and respawn
                nextY = '0;
            end
        endcase
    end

    always_ff @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            stepX <= '0;
            stepY <= '0;
            pos.x <= centerX;
            pos.y <= centerY;
        end
        else
        begin
            stepX <= nextX;
            stepY <= nextY;
            if (motionSel == respawn)
            begin
                pos.x <= centerX;
                pos.y <= centerY;
            end
            else
            begin
                pos.x <= pos.x + coordT'(stepX);  // Old step, wraps mod 1024
                pos.y <= pos.y + coordT'(stepY);
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/tankPkg.sv
/*
  Shared types of the player-tank block. One clock tick equals one video frame.
  Coordinates are unsigned screen pixels. Steps are two's complement.
  Trig values are sign-magnitude with magnitude scaled to 127.
*/
`default_nettype none

package tankPkg;

    // --------------------
    // Plain vectors
    // --------------------
    typedef logic [9:0]        coordT;    // Screen pixel
    typedef logic signed [9:0] stepT;     // Per-frame motion
    typedef logic [5:0]        headingT;  // 0..44, 8 degrees per count, CCW
    typedef logic [7:0]        trigT;     // Bit 7 sign, 6:0 magnitude
    typedef logic [7:0]        keyCodeT;  // Keyboard usage code

    localparam int headingCount = 45;     // Full turn in heading steps

    // --------------------
    // Grouped signals
    // --------------------
    typedef struct packed {
        coordT x;
        coordT y;
    } tankPosT;

    typedef struct packed {
        logic forward;
        logic reverse;
        logic rotLeft;
        logic rotRight;
        logic fire;
    } tankCmdT;                           // One-hot, zero when idle

    typedef struct packed {
        logic bottom;
        logic top;
        logic right;
        logic left;
    } wallFlagsT;

    typedef struct packed {
        trigT sin;
        trigT cos;
    } trigPairT;

    typedef enum logic [2:0] {
        holdStill,
        driveFwd,
        driveRev,
        bounce,
        respawn
    } motionSelT;

    typedef enum logic {
        fireReady,
        fireReload
    } fireStateT;

endpackage

`default_nettype wire

// File: rtl/tankTop.sv
/*
  Player tank, one update per frame. The clock port is Reset and the
  async active-high reset is frame_clk. Inputs are sampled at the clock edge.
  Position output is the tank centre. Size is the tankSize parameter.
*/
`timescale 1ns/1ps
`default_nettype none

module tankTop
#(
    parameter logic [6:0]     driveSpeed   = 7'd8,
    parameter int             reloadFrames = 6,
    parameter int             tankSize     = 10,
    parameter tankPkg::coordT centerX      = 10'd300,
    parameter tankPkg::coordT centerY      = 10'd250,
    parameter int             arenaXMin    = 0,
    parameter int             arenaXMax    = 639,
    parameter int             arenaYMin    = 0,
    parameter int             arenaYMax    = 479
)
(
    input  logic                   Reset,      // Frame clock
    input  logic                   frame_clk,  // Async reset, active high
    input  logic                   hit,
    input  tankPkg::keyCodeT [3:0] keycode,
    output tankPkg::tankPosT       tankPos,
    output tankPkg::stepT          stepX,
    output tankPkg::stepT          stepY,
    output tankPkg::headingT       heading,
    output logic                   shootBullet
);
    import tankPkg::*;

    tankCmdT   cmd;
    wallFlagsT walls;
    trigPairT  trig;
    motionSelT motionSel;

    keyDecoder u_keyDecoder (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .keycode   (keycode),
        .cmd       (cmd)
    );

    tankControl #(
        .reloadFrames (reloadFrames)
    ) u_tankControl (
        .Reset       (Reset),
        .frame_clk   (frame_clk),
        .hit         (hit),
        .cmd         (cmd),
        .walls       (walls),
        .heading     (heading),
        .motionSel   (motionSel),
        .shootBullet (shootBullet)
    );

    headingTrigTable u_headingTrigTable (
        .heading (heading),
        .trig    (trig)
    );

    tankMotion #(
        .driveSpeed (driveSpeed),
        .centerX    (centerX),
        .centerY    (centerY)
    ) u_tankMotion (
        .Reset     (Reset),
        .frame_clk (frame_clk),
        .motionSel (motionSel),
        .trig      (trig),
        .pos       (tankPos),
        .stepX     (stepX),
        .stepY     (stepY)
    );

    wallDetector #(
        .tankSize  (tankSize),
        .arenaXMin (arenaXMin),
        .arenaXMax (arenaXMax),
        .arenaYMin (arenaYMin),
        .arenaYMax (arenaYMax)
    ) u_wallDetector (
        .pos   (tankPos),
        .walls (walls)
    );

endmodule

`default_nettype wire

// File: rtl/wallDetector.sv
/*
  Wall flags from the current tank centre. A flag is set once the tank's
  size margin reaches a bound. Sums are taken in int, so no bound wraps.
  Screen y grows downward, so top is the small-y side.
*/
`timescale 1ns/1ps
`default_nettype none

module wallDetector
#(
    parameter int tankSize  = 10,
    parameter int arenaXMin = 0,
    parameter int arenaXMax = 639,
    parameter int arenaYMin = 0,
    parameter int arenaYMax = 479
)
(
    input  tankPkg::tankPosT   pos,
    output tankPkg::wallFlagsT walls
);
    int posX;  // Widened coordinates
    int posY;

    always_comb
    begin
        posX = int'(pos.x);
        posY = int'(pos.y);

        walls.left   = posX < arenaXMin + tankSize;
        walls.right  = posX + tankSize > arenaXMax;  // Margin moved to left side
        walls.top    = posY < arenaYMin + tankSize;
        walls.bottom = posY + tankSize > arenaYMax;
    end

endmodule

`default_nettype wire

// File: sim.f
rtl/tankPkg.sv
rtl/keyDecoder.sv
rtl/headingTrigTable.sv
rtl/wallDetector.sv
rtl/tankMotion.sv
rtl/tankControl.sv
rtl/tankTop.sv
verif/tankTop_checker.sv
verif/tankTb.sv

// File: verif/tankTb.sv
/*
  Testbench for the player tank with default parameters. One tick is one frame.
  Inputs change on the falling edge and outputs are checked there.
  Expected heading and command come from a reference model of the key rules.
*/
`timescale 1ns/1ps
`default_nettype none

module tankTb;
    import tankPkg::*;

    localparam int periodNs     = 4;
    localparam int driveSpeed   = 8;
    localparam int reloadFrames = 6;
    localparam int centerX      = 300;
    localparam int centerY      = 250;
    localparam int tankSize     = 10;
    localparam int arenaXMax    = 639;
    localparam int wallLimit    = 100;  // Frames allowed to reach the wall
    localparam int scriptFrames = 4 + 60 + 30 + 70 + wallLimit + 10 + 50;
    localparam int timeoutNs    = scriptFrames * periodNs + 400;

    // Priority order, highest first
    localparam keyCodeT [0:4] prioKeys = {8'h52, 8'h51, 8'h50, 8'h4F, 8'h2C};
    localparam keyCodeT keyFwd      = 8'h52;
    localparam keyCodeT keyRev      = 8'h51;
    localparam keyCodeT keyRotLeft  = 8'h50;
    localparam keyCodeT keyRotRight = 8'h4F;
    localparam keyCodeT keyFire     = 8'h2C;

    logic          Reset;      // Frame clock
    logic          frame_clk;  // Reset
    logic          hit;
    keyCodeT [3:0] keycode;
    tankPosT       tankPos;
    stepT          stepX;
    stepT          stepY;
    headingT       heading;
    logic          shootBullet;

    int          tbErrors;
    int          checkerErrors;
    logic [31:0] rngState;
    tankCmdT     expCmd;      // Model of the registered command
    headingT     expHeading;

    tankTop u_tankTop (
        .Reset       (Reset),
        .frame_clk   (frame_clk),
        .hit         (hit),
        .keycode     (keycode),
        .tankPos     (tankPos),
        .stepX       (stepX),
        .stepY       (stepY),
        .heading     (heading),
        .shootBullet (shootBullet)
    );

    always #(periodNs / 2) Reset = ~Reset;

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    function automatic tankCmdT pickCmd(input keyCodeT [3:0] slots);
        for (int p = 0; p < 5; p++)
            for (int s = 0; s < 4; s++)
                if (slots[s] == prioKeys[p])
                    return tankCmdT'(5'b10000 >> p);  // Forward is the MSB
        return '0;
    endfunction

    // Step from the trig rule, sign-magnitude table scaled to 127
    function automatic int expStep(input int h, input bit yAxis);
        real ang;
        real v;
        int  t;
        int  mag;
        ang = h * 8.0 * 3.14159265358979 / 180.0;
        v   = yAxis ? 127.0 * $sin(ang) : 127.0 * $cos(ang);
        t   = (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(0.5 - v);
        mag = (driveSpeed * ((t < 0) ? -t : t)) / 128;
        if (yAxis)
            return (t < 0) ? mag : -mag;  // Screen y grows downward
        return (t < 0) ? -mag : mag;
    endfunction

    task automatic expectEq(input string what, input int got, input int exp);
        assert (got == exp)
        else
        begin
            tbErrors++;
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic frames(input int n);
        repeat (n) @(negedge Reset);
    endtask

    task automatic expectCentre(input string when);
        expectEq({when, " x"}, int'(tankPos.x), centerX);
        expectEq({when, " y"}, int'(tankPos.y), centerY);
        expectEq({when, " heading"}, int'(heading), 0);
        expectEq({when, " stepX"}, int'(stepX), 0);
        expectEq({when, " stepY"}, int'(stepY), 0);
        expectEq({when, " shootBullet"}, int'(shootBullet), 0);
    endtask

    task automatic respawnTank();
        hit = 1'b1;
        frames(1);
        hit = 1'b0;
        expectCentre("respawn");
    endtask

    // --------------------
    // Reference model
    // --------------------
    always @(posedge Reset or posedge frame_clk)
    begin
        if (frame_clk)
        begin
            expCmd     = '0;
            expHeading = '0;
        end
        else
        begin
            if (hit)
                expHeading = '0;
            else if (expCmd.rotLeft)
                expHeading = (expHeading == headingCount - 1) ? '0 : expHeading + 1'b1;
            else if (expCmd.rotRight)
                expHeading = (expHeading == 0) ? headingT'(headingCount - 1) : expHeading - 1'b1;
            expCmd = pickCmd(keycode);  // One frame of decoder latency
        end
    end

    always @(negedge Reset)
    begin
        if (!frame_clk)
        begin
            expectEq("heading", int'(heading), int'(expHeading));
            expectEq("command", int'(u_tankTop.cmd), int'(expCmd));
        end
    end

    // --------------------
    // Tests
    // --------------------
    task automatic headingTest();
        keycode[1] = keyRotLeft;
        frames(50);
        keycode = '0;
        frames(2);
        expectEq("heading after 50 left turns", int'(heading), 50 % headingCount);
        respawnTank();
        keycode[3] = keyRotRight;
        frames(1);
        keycode = '0;
        frames(2);
        expectEq("heading after right turn from 0", int'(heading), headingCount - 1);
    endtask

    task automatic randomMix(input int n);
        logic [31:0] r;
        repeat (n)
        begin
            for (int s = 0; s < 4; s++)
            begin
                r          = nextRand();
                keycode[s] = {1'b1, r[30:24]};  // Never a game key
            end
            r = nextRand();
            for (int k = 0; k < 5; k++)
                if (r[27 + k])
                    keycode[r[10 + 2 * k +: 2]] = prioKeys[k];  // Random slot
            frames(1);
        end
        keycode = '0;
        frames(2);
    endtask

    task automatic driveAt(input int h);
        int wantX;
        int wantY;
        int lastX;
        int lastY;
        wantX = expStep(h, 1'b0);
        wantY = expStep(h, 1'b1);
        respawnTank();
        keycode[0] = keyRotLeft;
        frames(h);
        keycode = '0;
        frames(2);
        expectEq("turned heading", int'(heading), h);
        keycode[1] = keyFwd;
        frames(2);  // Decoder then step register
        expectEq("forward stepX", int'(stepX), wantX);
        expectEq("forward stepY", int'(stepY), wantY);
        repeat (3)
        begin
            lastX = int'(tankPos.x);
            lastY = int'(tankPos.y);
            frames(1);
            expectEq("x after one frame", int'(tankPos.x), lastX + wantX);
            expectEq("y after one frame", int'(tankPos.y), lastY + wantY);
        end
        keycode[1] = keyRev;
        frames(2);
        expectEq("reverse stepX", int'(stepX), -wantX);
        expectEq("reverse stepY", int'(stepY), -wantY);
        keycode = '0;
        frames(1);
    endtask

    task automatic wallBounce();
        int n;
        int edgeX;
        respawnTank();
        keycode[2] = keyFwd;
        edgeX = centerX;
        while (edgeX + tankSize <= arenaXMax)
            edgeX += expStep(0, 1'b0);  // First centre past the right margin
        n = 0;
        while (!u_tankTop.walls.right && n < wallLimit)
        begin
            frames(1);
            n++;
        end
        if (!u_tankTop.walls.right)
        begin
            tbErrors++;
            $display("Right wall flag never rose while driving toward the right wall");
        end
        expectEq("x when right flag rose", int'(tankPos.x), edgeX);
        frames(1);
        expectEq("stepX after wall", int'(stepX), -expStep(0, 1'b0));
        respawnTank();  // Forward still held
        keycode = '0;
        frames(1);
    endtask

    task automatic fireTest();
        int pulses;
        int lastAt;
        respawnTank();
        keycode[3] = keyFire;
        pulses     = 0;
        lastAt     = -1;
        for (int f = 0; f < 25; f++)
        begin
            frames(1);
            if (shootBullet)
            begin
                if (lastAt >= 0)
                    expectEq("frames between shots", f - lastAt, reloadFrames);
                lastAt = f;
                pulses++;
            end
        end
        expectEq("shots while fire held", pulses, 4);
        keycode = '0;
        respawnTank();
        keycode[0] = keyFire;
        keycode[2] = keyFwd;  // Drive key outranks fire
        pulses     = 0;
        repeat (10)
        begin
            frames(1);
            if (shootBullet)
                pulses++;
        end
        expectEq("shots with drive key held", pulses, 0);
        keycode = '0;
        frames(1);
    endtask

    initial
    begin
        Reset     = 1'b0;
        frame_clk = 1'b0;
        hit       = 1'b0;
        keycode   = '0;
        tbErrors  = 0;
        rngState  = 32'h91824976;
        #1 frame_clk = 1'b1;
        repeat (4) @(negedge Reset);
        frame_clk = 1'b0;
        expectCentre("reset");

        headingTest();
        randomMix(24);
        respawnTank();
        driveAt(0);
        driveAt(11);   // 88 deg
        driveAt(22);   // 176 deg
        wallBounce();
        fireTest();
        frames(2);

        checkerErrors = u_tankTop.u_checker.failCount;
        $display("Run complete: %0d testbench errors, %0d assertion failures",
                 tbErrors, checkerErrors);
        if (tbErrors + checkerErrors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(timeoutNs);
        $display("Timeout: the tests did not finish within the expected number of frames");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tankTop_checker.sv
/*
  Concurrent checks bound into every tankTop, sampled on the frame clock.
  The bind passes the instance parameters down, so limits follow the DUT.
  failCount is read by the testbench when it decides the verdict.
*/
`timescale 1ns/1ps
`default_nettype none

module tankTop_checker
#(
    parameter int             reloadFrames = 6,
    parameter int             tankSize     = 10,
    parameter tankPkg::coordT centerX      = 10'd300,
    parameter tankPkg::coordT centerY      = 10'd250,
    parameter int             arenaXMax    = 639,
    parameter int             arenaYMax    = 479
)
(
    input logic               Reset,      // Frame clock
    input logic               frame_clk,  // Async reset
    input logic               hit,
    input tankPkg::tankCmdT   cmd,
    input tankPkg::motionSelT motionSel,
    input tankPkg::tankPosT   tankPos,
    input tankPkg::stepT      stepX,
    input tankPkg::stepT      stepY,
    input tankPkg::headingT   heading,
    input logic               shootBullet
);
    import tankPkg::*;

    int failCount = 0;  // Failed assertion count

    // --------------------
    // Respawn and heading
    // --------------------
    respawnCentre: assert property (@(posedge Reset) disable iff (frame_clk)
        hit |=> tankPos.x == centerX && tankPos.y == centerY && heading == '0
                && stepX == '0 && stepY == '0 && !shootBullet)
    else
    begin
        failCount++;
        $error("Tank not at centre and idle one frame after hit");
    end

    headingLeft: assert property (@(posedge Reset) disable iff (frame_clk)
        !hit && cmd.rotLeft |=> heading == (($past(heading) == 6'd44) ? 6'd0
                                             : $past(heading) + 6'd1))
    else
    begin
        failCount++;
        $error("Left turn did not advance heading by one count");
    end

    // --------------------
    // Steps and position
    // --------------------
    bounceStep: assert property (@(posedge Reset) disable iff (frame_clk)
        motionSel == bounce |=> stepX == -$past(stepX) && stepY == -$past(stepY))
    else
    begin
        failCount++;
        $error("Bounce did not negate the step");
    end

    positionStep: assert property (@(posedge Reset) disable iff (frame_clk)
        motionSel != respawn |=> tankPos.x == coordT'($past(tankPos.x) + coordT'($past(stepX)))
                                 && tankPos.y == coordT'($past(tankPos.y) + coordT'($past(stepY))))
    else
    begin
        failCount++;
        $error("Position did not add the previous step");
    end

    arenaBounds: assert property (@(posedge Reset) disable iff (frame_clk)
        tankPos.x <= arenaXMax + tankSize && tankPos.y <= arenaYMax + tankSize)
    else
    begin
        failCount++;
        $error("Tank centre left the arena band");
    end

    // --------------------
    // Fire
    // --------------------
    firePulse: assert property (@(posedge Reset) disable iff (frame_clk || hit)
        shootBullet |-> $past(cmd.fire) ##1 !shootBullet [*reloadFrames-1])
    else
    begin
        failCount++;
        $error("Fire pulse without command or inside reload time");
    end

endmodule

bind tankTop tankTop_checker #(
    .reloadFrames (reloadFrames),
    .tankSize     (tankSize),
    .centerX      (centerX),
    .centerY      (centerY),
    .arenaXMax    (arenaXMax),
    .arenaYMax    (arenaYMax)
) u_checker (
    .Reset       (Reset),
    .frame_clk   (frame_clk),
    .hit         (hit),
    .cmd         (cmd),
    .motionSel   (motionSel),
    .tankPos     (tankPos),
    .stepX       (stepX),
    .stepY       (stepY),
    .heading     (heading),
    .shootBullet (shootBullet)
);

`default_nettype wire
